// ==== build.f ====
+incdir+.
i3c_target_pkg.sv
i3c_addr_match.sv
i3c_rx_path.sv
i3c_tx_path.sv
i3c_target_fsm.sv
i3c_target_top.sv
tb_i3c_target.sv

// ==== i3c_addr_match.sv ====
/*
  Address decoder of the I3C target.
  Latches the address byte on capture and reports main, virtual and broadcast hits.
*/
`timescale 1ns/10ps
`include "i3c_target_macros.svh"

module i3c_addr_match import i3c_target_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      addr_capture_i,
  input  logic      addr_clear_i,
  input  i3c_byte_t rx_byte_i,
  input  i3c_addr_t sta_addr_i,
  input  i3c_addr_t dyn_addr_i,
  input  i3c_addr_t virt_sta_addr_i,
  input  i3c_addr_t virt_dyn_addr_i,
  input  logic      sta_addr_valid_i,
  input  logic      dyn_addr_valid_i,
  input  logic      virt_sta_addr_valid_i,
  input  logic      virt_dyn_addr_valid_i,
  input  logic      bus_start_i,
  output logic      our_match_o,
  output logic      virt_match_o,
  output logic      bcast_match_o,
  output logic      rnw_o,
  output i3c_byte_t last_addr_o,
  output logic      last_addr_valid_o
);
  i3c_addr_t addr_q;
  logic      rnw_q;
  i3c_byte_t last_addr_q;

  // Dynamic address wins whenever it is assigned
  function automatic logic addr_hit(i3c_addr_t addr, i3c_addr_t dyn, logic dyn_vld,
                                    i3c_addr_t sta, logic sta_vld);
    if (dyn_vld) begin
      return dyn == addr;
    end
    return sta_vld && (sta == addr);
  endfunction

  // Address under decode, dropped while the engine idles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end else if (addr_capture_i) begin
      addr_q <= rx_byte_i[`I3C_BYTE_W-1:1];
      rnw_q  <= rx_byte_i[0];
    end else if (addr_clear_i) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end
  end

  // Last seen address byte stays visible after the transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_addr_q       <= '0;
      last_addr_valid_o <= 1'b0;
    end else begin
      if (addr_capture_i) last_addr_q <= rx_byte_i;
      // Any start invalidates it until the next address byte
      if (bus_start_i) last_addr_valid_o <= 1'b0;
      else if (addr_capture_i) last_addr_valid_o <= 1'b1;
    end
  end

  assign our_match_o  = addr_hit(addr_q, dyn_addr_i, dyn_addr_valid_i,
                                 sta_addr_i, sta_addr_valid_i);
  assign virt_match_o = addr_hit(addr_q, virt_dyn_addr_i, virt_dyn_addr_valid_i,
                                 virt_sta_addr_i, virt_sta_addr_valid_i);
  // Broadcast only counts with the write bit
  assign bcast_match_o = (addr_q == `I3C_BCAST_ADDR) && !rnw_q;
  assign rnw_o         = rnw_q;
  assign last_addr_o   = last_addr_q;

  // Distinct dynamic addresses never select both targets
  a_single_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dyn_addr_valid_i && virt_dyn_addr_valid_i && (dyn_addr_i != virt_dyn_addr_i))
    |-> !(our_match_o && virt_match_o));

endmodule : i3c_addr_match

// ==== i3c_rx_path.sv ====
/*
  Private write datapath of the I3C target.
  Holds each data byte, checks its T-bit and issues one FIFO write or one error pulse.
*/
`timescale 1ns/10ps

module i3c_rx_path import i3c_target_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      rx_byte_capture_i,
  input  logic      rx_tbit_check_i,
  input  i3c_byte_t rx_data_i,
  input  logic      rx_fifo_wready_i,
  input  logic      clear_i,
  output logic      rx_fifo_wvalid_o,
  output i3c_byte_t rx_fifo_wdata_o,
  output logic      parity_err_o,
  output logic      rx_overflow_err_o
);
  i3c_byte_t byte_q;
  logic      byte_held_q;
  logic      parity_ok;
  logic      check_en;

  // Data byte waiting for its T-bit
  always_ff @(posedge clk_i) begin
    if (rx_byte_capture_i) byte_q <= rx_data_i;
  end

  // Set by a byte and spent by its T-bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_held_q <= 1'b0;
    end else if (clear_i) begin
      byte_held_q <= 1'b0;
    end else if (rx_byte_capture_i) begin
      byte_held_q <= 1'b1;
    end else if (rx_tbit_check_i) begin
      byte_held_q <= 1'b0;
    end
  end

  // Odd parity over byte and T-bit with the T-bit in the LSB
  assign parity_ok = ^{byte_q, rx_data_i[0]};
  assign check_en  = rx_tbit_check_i && byte_held_q;

  // One of three outcomes per byte one cycle after the T-bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_fifo_wvalid_o  <= 1'b0;
      parity_err_o      <= 1'b0;
      rx_overflow_err_o <= 1'b0;
    end else begin
      rx_fifo_wvalid_o  <= check_en && parity_ok && rx_fifo_wready_i;
      parity_err_o      <= check_en && !parity_ok;
      // Full FIFO drops a good byte
      rx_overflow_err_o <= check_en && parity_ok && !rx_fifo_wready_i;
    end
  end

  assign rx_fifo_wdata_o = byte_q;

  // A write never comes with an error
  a_write_xor_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_fifo_wvalid_o |-> !(parity_err_o || rx_overflow_err_o));

endmodule : i3c_rx_path

// ==== i3c_target_fsm.sv ====
/*
  Primary protocol FSM of the I3C target.
  Follows frames from the bus engine, requests bus bytes and bits and strobes the datapaths.
*/
`timescale 1ns/10ps

module i3c_target_fsm import i3c_target_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      target_enable_i,
  input  logic      bus_start_det_i,
  input  logic      bus_rstart_det_i,
  input  logic      bus_stop_det_i,
  input  logic      bus_rx_done_i,
  input  i3c_byte_t bus_rx_data_i,
  input  logic      bus_tx_done_i,
  input  logic      our_match_i,
  input  logic      virt_match_i,
  input  logic      bcast_match_i,
  input  logic      rnw_i,
  input  logic      tx_desc_avail_i,
  input  logic      tx_fifo_rvalid_i,
  input  i3c_byte_t tx_byte_i,
  input  logic      tx_tbit_i,
  input  logic      tx_is_last_i,
  input  logic      ccc_done_i,
  output logic      bus_rx_req_byte_o,
  output logic      bus_rx_req_bit_o,
  output logic      bus_tx_req_byte_o,
  output logic      bus_tx_req_bit_o,
  output i3c_byte_t bus_tx_value_o,
  output logic      addr_capture_o,
  output logic      addr_clear_o,
  output logic      rx_byte_capture_o,
  output logic      rx_tbit_check_o,
  output logic      tx_pop_o,
  output i3c_ccc_t  ccc_o,
  output logic      ccc_valid_o,
  output logic      target_idle_o,
  output logic      xfer_in_progress_o,
  output logic      virtual_device_sel_o,
  output logic      event_target_nack_o
);
  target_state_e state_q, state_d;
  logic          bus_start_det;
  logic          addr_hit;
  logic          ccc_capture;
  i3c_ccc_t      ccc_q;

  // Start and repeated start restart decoding alike
  assign bus_start_det = bus_start_det_i | bus_rstart_det_i;
  assign addr_hit      = our_match_i | virt_match_i;

  always_comb begin
    state_d           = state_q;
    bus_rx_req_byte_o = 1'b0;
    bus_rx_req_bit_o  = 1'b0;
    bus_tx_req_byte_o = 1'b0;
    bus_tx_req_bit_o  = 1'b0;
    // SDA released when nothing is driven
    bus_tx_value_o    = i3c_byte_t'(1);
    addr_capture_o    = 1'b0;
    rx_byte_capture_o = 1'b0;
    rx_tbit_check_o   = 1'b0;
    ccc_capture       = 1'b0;
    case (state_q)
      Idle: if (target_enable_i && bus_start_det) state_d = RxFByte;
      RxFByte: begin
        bus_rx_req_byte_o = ~bus_start_det;
        if (bus_rx_done_i) begin
          addr_capture_o = 1'b1;
          state_d        = CheckFByte;
        end
      end
      // Broadcast or either target earns an ack
      CheckFByte: state_d = (bcast_match_i || addr_hit) ? TxAckFByte : Wait;
      TxAckFByte: begin
        bus_tx_req_bit_o = 1'b1;
        bus_tx_value_o   = '0;
        if (bus_tx_done_i) begin
          if (bcast_match_i) state_d = RxSByte;
          else if (addr_hit) state_d = rnw_i ? TxPReadData : RxPWriteData;
          else state_d = Wait;
        end
      end
      // CCC code, or an address if a repeated start comes first
      RxSByte: begin
        bus_rx_req_byte_o = ~bus_start_det;
        if (bus_start_det) begin
          state_d = RxSByteRepeated;
        end else if (bus_rx_done_i) begin
          ccc_capture = 1'b1;
          state_d     = DoCCC;
        end
      end
      RxSByteRepeated: begin
        bus_rx_req_byte_o = ~bus_start_det;
        if (bus_rx_done_i) begin
          addr_capture_o = 1'b1;
          state_d        = CheckSByte;
        end
      end
      // Reads need a descriptor ready
      CheckSByte: state_d = (addr_hit && (tx_desc_avail_i || !rnw_i)) ? TxAckSByte : Wait;
      TxAckSByte: begin
        bus_tx_req_bit_o = 1'b1;
        bus_tx_value_o   = '0;
        if (bus_tx_done_i) state_d = rnw_i ? TxPReadData : RxPWriteData;
      end
      RxPWriteData: begin
        bus_rx_req_byte_o = ~bus_start_det;
        if (bus_start_det) begin
          state_d = RxFByte;
        end else if (bus_rx_done_i) begin
          rx_byte_capture_o = 1'b1;
          state_d           = RxPWriteTbit;
        end
      end
      RxPWriteTbit: begin
        bus_rx_req_bit_o = ~bus_start_det;
        if (bus_start_det) begin
          state_d = RxFByte;
        end else if (bus_rx_done_i) begin
          rx_tbit_check_o = 1'b1;
          state_d         = RxPWriteData;
        end
      end
      TxPReadData: begin
        bus_tx_req_byte_o = 1'b1;
        bus_tx_value_o    = tx_byte_i;
        if (bus_start_det) state_d = RxFByte;
        else if (bus_tx_done_i) state_d = TxPReadTbit;
      end
      TxPReadTbit: begin
        bus_tx_req_bit_o = 1'b1;
        bus_tx_value_o   = i3c_byte_t'(tx_tbit_i);
        if (bus_start_det) begin
          state_d = RxFByte;
        end else if (bus_tx_done_i) begin
          // Next byte only if this one was not last and data is waiting
          state_d = (!tx_is_last_i && tx_fifo_rvalid_i) ? TxPReadData : Wait;
        end
      end
      Wait: if (bus_start_det) state_d = RxFByte;
      DoCCC: if (ccc_done_i) state_d = DoneCCC;
      DoneCCC: state_d = Idle;
      default: state_d = Idle;
    endcase
    // Stop wins over everything
    if (bus_stop_det_i) state_d = Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= Idle;
    else state_q <= state_d;
  end

  // CCC code for the outside handler
  always_ff @(posedge clk_i) begin
    if (ccc_capture) ccc_q <= bus_rx_data_i;
  end

  // Transfer flags decided at the address checks
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      virtual_device_sel_o <= 1'b0;
      xfer_in_progress_o   <= 1'b0;
      event_target_nack_o  <= 1'b0;
    end else begin
      case (state_q)
        Idle: xfer_in_progress_o <= 1'b0;
        CheckFByte: begin
          xfer_in_progress_o <= addr_hit;
          if (!bcast_match_i) virtual_device_sel_o <= virt_match_i;
        end
        CheckSByte: begin
          xfer_in_progress_o   <= addr_hit;
          virtual_device_sel_o <= virt_match_i;
        end
        default: ;
      endcase
      // Rejected address, one pulse on entering Wait
      event_target_nack_o <= (state_q inside {CheckFByte, CheckSByte}) && (state_d == Wait);
    end
  end

  // Pop as the read byte state is entered
  assign tx_pop_o      = (state_q != TxPReadData) && (state_d == TxPReadData);
  assign ccc_o         = ccc_q;
  assign ccc_valid_o   = (state_q == DoCCC);
  assign target_idle_o = (state_q == Idle);
  assign addr_clear_o  = (state_q == Idle);

  // The bus engine serves one request at a time
  a_one_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o}));

endmodule : i3c_target_fsm

// ==== i3c_target_macros.svh ====
/*
  Widths and protocol constants for the I3C target engine.
  Included by the package and by any RTL file that needs a constant.
*/
`ifndef I3C_TARGET_MACROS_SVH
`define I3C_TARGET_MACROS_SVH

// Target address width, without the read bit
`define I3C_ADDR_W 7

// Width of one bus byte and of one FIFO entry
`define I3C_BYTE_W 8

// Broadcast address, acked only with the write bit
`define I3C_BCAST_ADDR 7'h7E

// Encoding width of the primary FSM state
`define I3C_STATE_W 5

`endif

// ==== i3c_target_pkg.sv ====
/*
  Shared types of the I3C target engine.
  Modules take them with a wildcard import in their header.
*/
`include "i3c_target_macros.svh"

package i3c_target_pkg;

  // Seven-bit target address
  typedef logic [`I3C_ADDR_W-1:0] i3c_addr_t;

  // Bus byte, also the FIFO entry
  typedef logic [`I3C_BYTE_W-1:0] i3c_byte_t;

  // Common command code following the broadcast address
  typedef logic [`I3C_BYTE_W-1:0] i3c_ccc_t;

  // Primary protocol states
  typedef enum logic [`I3C_STATE_W-1:0] {
    Idle,
    RxFByte,
    CheckFByte,
    TxAckFByte,
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    RxPWriteData,
    RxPWriteTbit,
    TxPReadData,
    TxPReadTbit,
    Wait,
    DoCCC,
    DoneCCC
  } target_state_e;

endpackage : i3c_target_pkg

// ==== i3c_target_top.sv ====
/*
  Top of the I3C target protocol engine.
  Connects the FSM to the address decoder and the RX and TX datapaths.
*/
`timescale 1ns/10ps

module i3c_target_top import i3c_target_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      target_enable_i,
  input  logic      bus_start_det_i,
  input  logic      bus_rstart_det_i,
  input  logic      bus_stop_det_i,
  input  logic      bus_rx_done_i,
  input  i3c_byte_t bus_rx_data_i,
  input  logic      bus_tx_done_i,
  output logic      bus_rx_req_byte_o,
  output logic      bus_rx_req_bit_o,
  output logic      bus_tx_req_byte_o,
  output logic      bus_tx_req_bit_o,
  output i3c_byte_t bus_tx_value_o,
  input  i3c_addr_t sta_addr_i,
  input  i3c_addr_t dyn_addr_i,
  input  i3c_addr_t virt_sta_addr_i,
  input  i3c_addr_t virt_dyn_addr_i,
  input  logic      sta_addr_valid_i,
  input  logic      dyn_addr_valid_i,
  input  logic      virt_sta_addr_valid_i,
  input  logic      virt_dyn_addr_valid_i,
  output i3c_byte_t last_addr_o,
  output logic      last_addr_valid_o,
  output logic      rx_fifo_wvalid_o,
  output i3c_byte_t rx_fifo_wdata_o,
  input  logic      rx_fifo_wready_i,
  output logic      parity_err_o,
  output logic      rx_overflow_err_o,
  input  logic      tx_desc_avail_i,
  input  logic      tx_fifo_rvalid_i,
  output logic      tx_fifo_rready_o,
  input  i3c_byte_t tx_fifo_rdata_i,
  input  logic      tx_last_i,
  output i3c_ccc_t  ccc_o,
  output logic      ccc_valid_o,
  input  logic      ccc_done_i,
  output logic      target_idle_o,
  output logic      xfer_in_progress_o,
  output logic      virtual_device_sel_o,
  output logic      event_target_nack_o
);
  logic      our_match, virt_match, bcast_match, rnw;
  logic      addr_capture, addr_clear;
  logic      rx_byte_capture, rx_tbit_check;
  logic      tx_pop;
  i3c_byte_t tx_byte;
  logic      tx_tbit, tx_is_last;

  i3c_target_fsm u_fsm (
    .clk_i, .rst_ni, .target_enable_i,
    .bus_start_det_i, .bus_rstart_det_i, .bus_stop_det_i,
    .bus_rx_done_i, .bus_rx_data_i, .bus_tx_done_i,
    .our_match_i   (our_match),
    .virt_match_i  (virt_match),
    .bcast_match_i (bcast_match),
    .rnw_i         (rnw),
    .tx_desc_avail_i, .tx_fifo_rvalid_i,
    .tx_byte_i     (tx_byte),
    .tx_tbit_i     (tx_tbit),
    .tx_is_last_i  (tx_is_last),
    .ccc_done_i,
    .bus_rx_req_byte_o, .bus_rx_req_bit_o, .bus_tx_req_byte_o, .bus_tx_req_bit_o,
    .bus_tx_value_o,
    .addr_capture_o    (addr_capture),
    .addr_clear_o      (addr_clear),
    .rx_byte_capture_o (rx_byte_capture),
    .rx_tbit_check_o   (rx_tbit_check),
    .tx_pop_o          (tx_pop),
    .ccc_o, .ccc_valid_o, .target_idle_o, .xfer_in_progress_o,
    .virtual_device_sel_o, .event_target_nack_o
  );

  i3c_addr_match u_addr_match (
    .clk_i, .rst_ni,
    .addr_capture_i (addr_capture),
    .addr_clear_i   (addr_clear),
    .rx_byte_i      (bus_rx_data_i),
    .sta_addr_i, .dyn_addr_i, .virt_sta_addr_i, .virt_dyn_addr_i,
    .sta_addr_valid_i, .dyn_addr_valid_i, .virt_sta_addr_valid_i, .virt_dyn_addr_valid_i,
    .bus_start_i    (bus_start_det_i | bus_rstart_det_i),
    .our_match_o    (our_match),
    .virt_match_o   (virt_match),
    .bcast_match_o  (bcast_match),
    .rnw_o          (rnw),
    .last_addr_o, .last_addr_valid_o
  );

  // Held byte is dropped whenever the engine idles
  i3c_rx_path u_rx_path (
    .clk_i, .rst_ni,
    .rx_byte_capture_i (rx_byte_capture),
    .rx_tbit_check_i   (rx_tbit_check),
    .rx_data_i         (bus_rx_data_i),
    .rx_fifo_wready_i,
    .clear_i           (addr_clear),
    .rx_fifo_wvalid_o, .rx_fifo_wdata_o, .parity_err_o, .rx_overflow_err_o
  );

  i3c_tx_path u_tx_path (
    .clk_i, .rst_ni,
    .tx_pop_i        (tx_pop),
    .tx_fifo_rdata_i,
    .tx_last_i,
    .tx_byte_o       (tx_byte),
    .tx_tbit_o       (tx_tbit),
    .tx_is_last_o    (tx_is_last)
  );

  // The FSM pop is the FIFO read strobe
  assign tx_fifo_rready_o = tx_pop;

endmodule : i3c_target_top

// ==== i3c_tx_path.sv ====
/*
  Private read datapath of the I3C target.
  Captures the popped TX FIFO byte with its last flag and forms the read T-bit.
*/
`timescale 1ns/10ps

module i3c_tx_path import i3c_target_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      tx_pop_i,
  input  i3c_byte_t tx_fifo_rdata_i,
  input  logic      tx_last_i,
  output i3c_byte_t tx_byte_o,
  output logic      tx_tbit_o,
  output logic      tx_is_last_o
);
  i3c_byte_t byte_q;
  logic      last_q;

  // FIFO head is valid in the pop cycle
  always_ff @(posedge clk_i) begin
    if (tx_pop_i) byte_q <= tx_fifo_rdata_i;
  end

  // Last flag travels with its byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= 1'b0;
    end else if (tx_pop_i) begin
      last_q <= tx_last_i;
    end
  end

  assign tx_byte_o    = byte_q;
  assign tx_is_last_o = last_q;
  // Low T-bit ends the read
  assign tx_tbit_o    = ~last_q;

endmodule : i3c_tx_path

// ==== run_sim.sh ====
#!/bin/bash
# Builds and runs the I3C target testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_i3c_target \
  -o sim_tb > sim.log 2>&1 \
  && ./obj_dir/sim_tb >> sim.log 2>&1 \
  || echo "TEST FAIL" >> sim.log
cat sim.log
if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== tb_i3c_target.sv ====
/*
  Testbench of the I3C target engine, with bus engine and FIFO models.
  Runs six directed tests and prints one line per test and a closing summary.
*/
`timescale 1ns/10ps

module tb_i3c_target;
  logic clk_i, rst_ni, target_enable_i, ccc_done_i;
  logic bus_start_det_i, bus_rstart_det_i, bus_stop_det_i;
  logic bus_rx_done_i, bus_tx_done_i, rx_fifo_wready_i;
  logic [7:0] bus_rx_data_i, bus_tx_value_o, last_addr_o, rx_fifo_wdata_o, ccc_o;
  logic bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o;
  logic [6:0] sta_addr_i, dyn_addr_i, virt_sta_addr_i, virt_dyn_addr_i;
  logic sta_addr_valid_i, dyn_addr_valid_i, virt_sta_addr_valid_i, virt_dyn_addr_valid_i;
  logic last_addr_valid_o, rx_fifo_wvalid_o, parity_err_o, rx_overflow_err_o;
  logic tx_desc_avail_i, tx_fifo_rvalid_i, tx_fifo_rready_o, tx_last_i;
  logic [7:0] tx_fifo_rdata_i;
  logic ccc_valid_o, target_idle_o, xfer_in_progress_o, virtual_device_sel_o;
  logic event_target_nack_o;

  // Stimulus and record queues
  logic [7:0] rx_q[$], wr_bytes[$], rx_exp[$], tx_bytes[$], tx_bits[$], txf_data[$];
  logic       txf_last[$];
  integer seed = 76;
  int cycles, errors, checks, tests, bit_idx, ovf_idx;
  int nack_cnt, par_cnt, ovf_cnt, pop_cnt;
  logic ack_req_seen;

  i3c_target_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Watchdog on the whole run
  initial begin
    cycles = 0;
    while (cycles < 20000) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within 20000 cycles");
    $display("TEST FAIL");
    $finish;
  end

  // T-bit that gives odd parity over byte and T-bit
  function automatic logic odd_tbit(logic [7:0] b);
    return ~^b;
  endfunction

  // Dynamic address takes precedence over static
  function automatic logic target_matches(logic [6:0] a, logic [6:0] dyn, logic dyn_v,
                                          logic [6:0] sta, logic sta_v);
    if (dyn_v) return a == dyn;
    return sta_v && (a == sta);
  endfunction

  task automatic check(string msg, logic [7:0] got, logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // Bus engine model answers each request after 2 to 5 cycles
  initial begin
    int delay;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      if (bus_rx_req_byte_o || bus_rx_req_bit_o || bus_tx_req_byte_o || bus_tx_req_bit_o) begin
        delay = 2 + ($random(seed) & 3);
        repeat (delay) @(posedge clk_i);
        #1;
        if ((bus_rx_req_byte_o || bus_rx_req_bit_o) && rx_q.size() > 0) begin
          if (bus_rx_req_bit_o) begin
            // Overflow test holds wready low for one T-bit
            rx_fifo_wready_i = (bit_idx != ovf_idx);
            bit_idx++;
          end
          bus_rx_data_i = rx_q.pop_front();
          bus_rx_done_i = 1'b1;
        end else if (bus_tx_req_byte_o) begin
          tx_bytes.push_back(bus_tx_value_o);
          bus_tx_done_i = 1'b1;
        end else if (bus_tx_req_bit_o) begin
          tx_bits.push_back({7'd0, bus_tx_value_o[0]});
          bus_tx_done_i = 1'b1;
        end
        @(posedge clk_i);
        #1;
        bus_rx_done_i    = 1'b0;
        bus_tx_done_i    = 1'b0;
        rx_fifo_wready_i = 1'b1;
      end
    end
  end

  // FIFO models and event counters sample at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (rx_fifo_wvalid_o) begin
        if (rx_exp.size() == 0) begin
          errors++;
          $display("Unexpected RX FIFO write of %0h at %0t", rx_fifo_wdata_o, $time);
        end else begin
          check("RX FIFO data", rx_fifo_wdata_o, rx_exp.pop_front());
        end
      end
      if (tx_fifo_rready_o && txf_data.size() > 0) begin
        void'(txf_data.pop_front());
        void'(txf_last.pop_front());
        pop_cnt++;
      end
      if (event_target_nack_o) nack_cnt++;
      if (parity_err_o) par_cnt++;
      if (rx_overflow_err_o) ovf_cnt++;
      if (bus_tx_req_bit_o) ack_req_seen = 1'b1;
    end
  end

  // Head of the TX FIFO model follows its queue
  always @(posedge clk_i) begin
    #1;
    tx_fifo_rvalid_i = txf_data.size() > 0;
    tx_desc_avail_i  = txf_data.size() > 0;
    tx_fifo_rdata_i  = (txf_data.size() > 0) ? txf_data[0] : 8'h00;
    tx_last_i        = (txf_last.size() > 0) ? txf_last[0] : 1'b0;
  end

  task automatic start_frame();
    @(posedge clk_i);
    #1 bus_start_det_i = 1'b1;
    @(posedge clk_i);
    #1 bus_start_det_i = 1'b0;
  endtask

  task automatic stop_frame();
    @(posedge clk_i);
    #1 bus_stop_det_i = 1'b1;
    @(posedge clk_i);
    #1 bus_stop_det_i = 1'b0;
    while (!target_idle_o) @(negedge clk_i);
  endtask

  // Sends the address and each byte with its T-bit and waits for the next byte request
  task automatic write_frame(logic [6:0] addr, int bad_idx, int ovf);
    logic tb;
    bit_idx = 0;
    ovf_idx = ovf;
    rx_q.push_back({addr, 1'b0});
    foreach (wr_bytes[i]) begin
      tb = odd_tbit(wr_bytes[i]);
      if (i == bad_idx) tb = ~tb;
      rx_q.push_back(wr_bytes[i]);
      rx_q.push_back({7'd0, tb});
      if (i != bad_idx && i != ovf) rx_exp.push_back(wr_bytes[i]);
    end
    wr_bytes.delete();
    start_frame();
    while (rx_q.size() != 0 || !bus_rx_req_byte_o) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
  endtask

  task automatic finish_test(string name, int err_before);
    check("RX FIFO writes missing", 8'(rx_exp.size()), 8'd0);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
    rx_exp.delete();
    rx_q.delete();
    tx_bytes.delete();
    tx_bits.delete();
    nack_cnt = 0;
    par_cnt = 0;
    ovf_cnt = 0;
    pop_cnt = 0;
    ack_req_seen = 1'b0;
  endtask

  initial begin
    int e;
    logic hit;
    rst_ni = 1'b0;
    target_enable_i = 1'b1;
    ccc_done_i = 1'b0;
    bus_start_det_i = 1'b0;
    bus_rstart_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    bus_rx_done_i = 1'b0;
    bus_tx_done_i = 1'b0;
    bus_rx_data_i = 8'h00;
    rx_fifo_wready_i = 1'b1;
    tx_desc_avail_i = 1'b0;
    tx_fifo_rvalid_i = 1'b0;
    tx_fifo_rdata_i = 8'h00;
    tx_last_i = 1'b0;
    sta_addr_i = 7'h50;
    dyn_addr_i = 7'h2A;
    virt_sta_addr_i = 7'h33;
    virt_dyn_addr_i = 7'h00;
    sta_addr_valid_i = 1'b1;
    dyn_addr_valid_i = 1'b1;
    virt_sta_addr_valid_i = 1'b1;
    virt_dyn_addr_valid_i = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    ovf_idx = -1;
    bit_idx = 0;
    nack_cnt = 0;
    par_cnt = 0;
    ovf_cnt = 0;
    pop_cnt = 0;
    ack_req_seen = 1'b0;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    check("Idle after reset", {7'd0, target_idle_o}, 8'd1);
    check("Requests and strobes low after reset",
          {bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o,
           tx_fifo_rready_o, rx_fifo_wvalid_o, parity_err_o, rx_overflow_err_o}, 8'd0);
    check("Flags low after reset",
          {4'd0, ccc_valid_o, xfer_in_progress_o, virtual_device_sel_o, event_target_nack_o},
          8'd0);

    // Write to the dynamic address
    e = errors;
    wr_bytes = '{8'hA5, 8'h3C, 8'h0F};
    write_frame(7'h2A, -1, -1);
    check("Last address", last_addr_o, {7'h2A, 1'b0});
    check("Last address valid", {7'd0, last_addr_valid_o}, 8'd1);
    check("Transfer in progress", {7'd0, xfer_in_progress_o},
          {7'd0, target_matches(7'h2A, dyn_addr_i, dyn_addr_valid_i,
                                sta_addr_i, sta_addr_valid_i)});
    stop_frame();
    finish_test("private write", e);

    // Wrong T-bit on the middle byte
    e = errors;
    wr_bytes = '{8'h11, 8'h22, 8'h33};
    write_frame(7'h2A, 1, -1);
    check("Parity error pulses", 8'(par_cnt), 8'd1);
    stop_frame();
    finish_test("parity error", e);

    // Read three bytes with the last flag on the third
    e = errors;
    txf_data = '{8'hC1, 8'hD2, 8'hE3};
    txf_last = '{1'b0, 1'b0, 1'b1};
    rx_q.push_back({7'h2A, 1'b1});
    start_frame();
    while (tx_bits.size() < 4) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    check("Read byte count", 8'(tx_bytes.size()), 8'd3);
    check("Read byte 0", tx_bytes[0], 8'hC1);
    check("Read byte 1", tx_bytes[1], 8'hD2);
    check("Read byte 2", tx_bytes[2], 8'hE3);
    check("Ack value", tx_bits[0], 8'd0);
    check("T-bit 0", tx_bits[1], 8'd1);
    check("T-bit 1", tx_bits[2], 8'd1);
    check("T-bit 2", tx_bits[3], 8'd0);
    check("TX FIFO pops", 8'(pop_cnt), 8'd3);
    stop_frame();
    finish_test("private read", e);

    // No match with static addresses only and then the virtual target
    e = errors;
    dyn_addr_valid_i = 1'b0;
    hit = target_matches(7'h11, dyn_addr_i, dyn_addr_valid_i, sta_addr_i, sta_addr_valid_i) ||
          target_matches(7'h11, virt_dyn_addr_i, virt_dyn_addr_valid_i,
                         virt_sta_addr_i, virt_sta_addr_valid_i);
    rx_q.push_back({7'h11, 1'b0});
    start_frame();
    while (rx_q.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    check("No ack request", {7'd0, ack_req_seen}, {7'd0, hit});
    check("No transfer in progress", {7'd0, xfer_in_progress_o}, {7'd0, hit});
    check("NACK event pulses", 8'(nack_cnt), 8'd1);
    stop_frame();
    wr_bytes = '{8'h5A};
    write_frame(7'h33, -1, -1);
    check("Virtual select", {7'd0, virtual_device_sel_o},
          {7'd0, target_matches(7'h33, virt_dyn_addr_i, virt_dyn_addr_valid_i,
                                virt_sta_addr_i, virt_sta_addr_valid_i)});
    stop_frame();
    dyn_addr_valid_i = 1'b1;
    finish_test("nack and virtual target", e);

    // Broadcast write followed by a CCC code
    e = errors;
    rx_q.push_back({7'h7E, 1'b0});
    rx_q.push_back(8'h07);
    start_frame();
    while (!ccc_valid_o) @(negedge clk_i);
    check("CCC code", ccc_o, 8'h07);
    repeat (5) @(negedge clk_i);
    check("CCC valid held", {7'd0, ccc_valid_o}, 8'd1);
    @(posedge clk_i);
    #1 ccc_done_i = 1'b1;
    @(posedge clk_i);
    #1 ccc_done_i = 1'b0;
    while (!target_idle_o) @(negedge clk_i);
    check("CCC valid cleared", {7'd0, ccc_valid_o}, 8'd0);
    finish_test("broadcast CCC", e);

    // FIFO full during the second byte
    e = errors;
    wr_bytes = '{8'h81, 8'h42, 8'h24};
    write_frame(7'h2A, -1, 1);
    check("Overflow pulses", 8'(ovf_cnt), 8'd1);
    stop_frame();
    ovf_idx = -1;
    finish_test("RX overflow", e);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_i3c_target
